/* verilog/os_gen_settings.svh */
`ifndef OS_GEN_SETTINGS_SVH
`define OS_GEN_SETTINGS_SVH

// link geometry
`define OS_MAX_LANES 16
`define OS_SYMBOL_W 8

// ordered set lengths in symbols
`define OS_TS_LEN 16
`define OS_SHORT_LEN 4

// K codes
`define OS_COM 8'hBC
`define OS_PAD 8'hF7
`define OS_SKP 8'h1C
`define OS_EIE 8'h7C

// training set identifiers as D codes
`define OS_TS1_ID 8'h4A
`define OS_TS2_ID 8'h45

`endif

/* verilog/os_gen_pkg.sv */
`include "os_gen_settings.svh"

package os_gen_pkg;

   // requested ordered set with anything above EIOS folded to IDLE at capture
   typedef enum logic [2:0] {
      TS1  = 3'd0,
      TS2  = 3'd1,
      SKP  = 3'd2,
      EIOS = 3'd3,
      IDLE = 3'd4
   } os_type_e;

   typedef enum logic [1:0] {
      PAD     = 2'd0,   // lane number field carries PAD
      ASCEND  = 2'd1,   // lane i gets i
      DESCEND = 2'd2    // lane i gets lanes-1-i
   } lane_mode_e;

   typedef struct packed {
      os_type_e   os_type;
      logic [7:0] link_field;  // link number or PAD
      logic       link_is_pad;
      logic [7:0] rate_id;     // data rate identifier
      logic [7:0] ctrl;        // training control
      lane_mode_e lane_mode;
   } os_request_t;

   typedef struct packed {
      logic [`OS_SYMBOL_W-1:0] data;
      logic                    is_k;
      logic                    lane_field;  // per-lane value is placed by the driver
      lane_mode_e              lane_mode;
      logic                    first;
      logic                    last;
      logic                    idle;        // finish marker without a set
   } os_symbol_t;

endpackage

/* verilog/os_request_capture.sv */
`include "os_gen_settings.svh"

module os_request_capture (
   input  logic                    pclk,
   input  logic                    reset_n,
   input  logic                    start,
   input  logic [2:0]              os_type,
   input  logic [1:0]              lane_mode,
   input  logic [7:0]              link_number,
   input  logic [2:0]              rate,
   input  logic                    loopback,
   input  logic                    seq_done,
   output os_gen_pkg::os_request_t req,
   output logic                    req_load,
   output logic                    busy
);
   import os_gen_pkg::*;

   logic        accept;
   logic        done_q;   // last symbol has reached the driver
   os_request_t req_next;

   assign accept = start & ~busy;   // start while busy is dropped

   always_comb begin
      req_next.os_type     = (os_type > 3'd3) ? IDLE : os_type_e'(os_type);
      req_next.link_is_pad = (link_number == 8'h00);
      req_next.link_field  = req_next.link_is_pad ? `OS_PAD : link_number;
      case (rate)
         3'd1:    req_next.rate_id = 8'h02;
         3'd2:    req_next.rate_id = 8'h04;
         3'd3:    req_next.rate_id = 8'h08;
         3'd4:    req_next.rate_id = 8'h10;
         default: req_next.rate_id = 8'h20;
      endcase
      req_next.ctrl      = loopback ? 8'h04 : 8'h00;   // loopback bit
      req_next.lane_mode = lane_mode[1] ? DESCEND : lane_mode_e'(lane_mode);
   end

   always_ff @(posedge pclk or negedge reset_n) begin
      if (!reset_n) begin
         busy     <= 1'b0;
         req_load <= 1'b0;
         done_q   <= 1'b0;
      end else begin
         req_load <= accept;
         done_q   <= seq_done;
         if (accept)
            busy <= 1'b1;
         else if (done_q)
            busy <= 1'b0;   // drops once finish has been driven
      end
   end

   always_ff @(posedge pclk) begin
      if (accept)
         req <= req_next;   // held stable for the whole set
   end

endmodule

/* verilog/os_symbol_sequencer.sv */
`include "os_gen_settings.svh"

module os_symbol_sequencer (
   input  logic                    pclk,
   input  logic                    reset_n,
   input  os_gen_pkg::os_request_t req,
   input  logic                    req_load,
   output os_gen_pkg::os_symbol_t  sym,
   output logic                    sym_en,
   output logic                    seq_done
);
   import os_gen_pkg::*;

   localparam int cnt_w = $clog2(`OS_TS_LEN);

   logic [cnt_w-1:0] cnt;
   logic [cnt_w-1:0] idx;       // index of the symbol presented now
   logic [cnt_w-1:0] last_idx;
   logic             active;
   logic [7:0]       ts_id;

   assign idx      = req_load ? '0 : cnt;   // symbol 0 goes out with the load pulse
   assign sym_en   = req_load | active;
   assign seq_done = sym_en & sym.last;
   assign ts_id    = (req.os_type == TS2) ? `OS_TS2_ID : `OS_TS1_ID;

   always_comb begin
      case (req.os_type)
         TS1, TS2:  last_idx = cnt_w'(`OS_TS_LEN - 1);
         SKP, EIOS: last_idx = cnt_w'(`OS_SHORT_LEN - 1);
         default:   last_idx = '0;   // idle is a single marker
      endcase
   end

   always_comb begin
      sym           = '0;
      sym.lane_mode = req.lane_mode;
      sym.first     = (idx == '0);
      sym.last      = (idx == last_idx);
      case (req.os_type)
         TS1, TS2: begin
            case (idx)
               4'd0: begin
                  sym.data = `OS_COM;
                  sym.is_k = 1'b1;
               end
               4'd1: begin
                  sym.data = req.link_field;
                  sym.is_k = req.link_is_pad;   // PAD is a K code
               end
               4'd2:    sym.lane_field = 1'b1;
               4'd3:    sym.data = 8'h00;        // N_FTS
               4'd4:    sym.data = req.rate_id;
               4'd5:    sym.data = req.ctrl;
               default: sym.data = ts_id;
            endcase
         end
         SKP: begin
            sym.data = (idx == '0) ? `OS_COM : `OS_SKP;
            sym.is_k = 1'b1;
         end
         EIOS: begin
            sym.data = (idx == '0) ? `OS_COM : `OS_EIE;
            sym.is_k = 1'b1;
         end
         default: sym.idle = 1'b1;
      endcase
   end

   always_ff @(posedge pclk or negedge reset_n) begin
      if (!reset_n) begin
         active <= 1'b0;
         cnt    <= '0;
      end else if (sym_en) begin
         if (sym.last) begin
            active <= 1'b0;
            cnt    <= '0;
         end else begin
            active <= 1'b1;
            cnt    <= idx + 1'b1;
         end
      end
   end

endmodule

/* verilog/pipe_lane_driver.sv */
`include "os_gen_settings.svh"

module pipe_lane_driver #(
   parameter int lanes = 16
) (
   input  logic                   pclk,
   input  logic                   reset_n,
   input  os_gen_pkg::os_symbol_t sym,
   input  logic                   sym_en,
   output logic [lanes*8-1:0]     tx_data,
   output logic [lanes-1:0]       tx_datak,
   output logic [lanes-1:0]       tx_valid,
   output logic                   finish
);
   import os_gen_pkg::*;

   if (lanes < 1 || lanes > `OS_MAX_LANES) begin : g_lane_check
      $error("pipe_lane_driver: lanes must be 1 to %0d", `OS_MAX_LANES);
   end

   logic                 in_set;   // between first and last symbol
   logic                 send;
   logic [lanes*8-1:0]   data_next;
   logic [lanes-1:0]     k_next;

   assign send = sym_en & ~sym.idle & (sym.first | in_set);

   always_comb begin
      for (int i = 0; i < lanes; i++) begin
         data_next[i*8 +: 8] = sym.data;
         k_next[i]           = sym.is_k;
         if (sym.lane_field) begin
            case (sym.lane_mode)
               PAD: begin
                  data_next[i*8 +: 8] = `OS_PAD;
                  k_next[i]           = 1'b1;
               end
               ASCEND: begin
                  data_next[i*8 +: 8] = 8'(i);
                  k_next[i]           = 1'b0;
               end
               default: begin
                  data_next[i*8 +: 8] = 8'(lanes - 1 - i);   // reversed numbering
                  k_next[i]           = 1'b0;
               end
            endcase
         end
      end
   end

   always_ff @(posedge pclk or negedge reset_n) begin
      if (!reset_n) begin
         tx_data  <= '0;
         tx_datak <= '0;
         tx_valid <= '0;
         finish   <= 1'b0;
         in_set   <= 1'b0;
      end else begin
         finish <= sym_en & (sym.last | sym.idle);
         if (sym_en)
            in_set <= (sym.first | in_set) & ~sym.last & ~sym.idle;
         if (send) begin
            tx_data  <= data_next;
            tx_datak <= k_next;
            tx_valid <= '1;
         end else begin
            tx_data  <= '0;   // quiet lanes between sets
            tx_datak <= '0;
            tx_valid <= '0;
         end
      end
   end

endmodule

/* verilog/os_gen_top.sv */
module os_gen_top #(
   parameter int lanes = 16
) (
   input  logic               pclk,
   input  logic               reset_n,
   input  logic               start,
   input  logic [2:0]         os_type,
   input  logic [1:0]         lane_mode,
   input  logic [7:0]         link_number,
   input  logic [2:0]         rate,
   input  logic               loopback,
   output logic [lanes*8-1:0] tx_data,
   output logic [lanes-1:0]   tx_datak,
   output logic [lanes-1:0]   tx_valid,
   output logic               busy,
   output logic               finish
);
   import os_gen_pkg::*;

   os_request_t req;        // captured and encoded request
   logic        req_load;
   logic        seq_done;
   os_symbol_t  sym;        // current symbol, shared by all lanes
   logic        sym_en;

   os_request_capture capture_i (
      .pclk        (pclk),
      .reset_n     (reset_n),
      .start       (start),
      .os_type     (os_type),
      .lane_mode   (lane_mode),
      .link_number (link_number),
      .rate        (rate),
      .loopback    (loopback),
      .seq_done    (seq_done),
      .req         (req),
      .req_load    (req_load),
      .busy        (busy)
   );

   os_symbol_sequencer sequencer_i (
      .pclk     (pclk),
      .reset_n  (reset_n),
      .req      (req),
      .req_load (req_load),
      .sym      (sym),
      .sym_en   (sym_en),
      .seq_done (seq_done)
   );

   pipe_lane_driver #(.lanes(lanes)) driver_i (
      .pclk     (pclk),
      .reset_n  (reset_n),
      .sym      (sym),
      .sym_en   (sym_en),
      .tx_data  (tx_data),
      .tx_datak (tx_datak),
      .tx_valid (tx_valid),
      .finish   (finish)
   );

endmodule

/* bench/os_gen_assertions.sv */
module os_gen_assertions #(
   parameter int lanes = 16
) (
   input logic             pclk,
   input logic             reset_n,
   input logic             start,
   input logic             busy,
   input logic             finish,
   input logic [lanes-1:0] tx_valid
);
   timeunit 1ns;
   timeprecision 100ps;

   finish_pulse: assert property (@(posedge pclk) disable iff (!reset_n)
      finish |=> !finish)   // finish is a strobe
      else $error("finish stayed high for more than one cycle");

   lanes_quiet: assert property (@(posedge pclk) disable iff (!reset_n)
      !busy |-> tx_valid == '0)
      else $error("tx_valid active while busy is low");

   busy_cause: assert property (@(posedge pclk) disable iff (!reset_n)
      $rose(busy) |-> $past(start))   // only an accepted start raises busy
      else $error("busy rose without a start on the previous cycle");

endmodule

bind os_gen_top os_gen_assertions #(.lanes(lanes)) assertions_i (
   .pclk     (pclk),
   .reset_n  (reset_n),
   .start    (start),
   .busy     (busy),
   .finish   (finish),
   .tx_valid (tx_valid)
);

/* bench/os_gen_tb.sv */
`include "os_gen_settings.svh"

module os_gen_tb;
   timeunit 1ns;
   timeprecision 100ps;

   localparam int lanes    = 16;
   localparam int num_reqs = 80;
   localparam int max_wait = 40;   // cycles

   logic               pclk = 1'b0;
   logic               reset_n;
   logic               start;
   logic [2:0]         os_type;
   logic [1:0]         lane_mode;
   logic [7:0]         link_number;
   logic [2:0]         rate;
   logic               loopback;
   logic [lanes*8-1:0] tx_data;
   logic [lanes-1:0]   tx_datak;
   logic [lanes-1:0]   tx_valid;
   logic               busy;
   logic               finish;

   logic [31:0]        rng_state;
   logic [lanes*8-1:0] exp_data [`OS_TS_LEN];   // expected lanes per symbol
   logic [lanes-1:0]   exp_k [`OS_TS_LEN];
   int                 exp_len;                  // 0 for an idle request
   int                 checks;
   int                 errors;
   int                 timeouts;
   int                 req_num;
   int                 slot;                     // cycles since start was sampled

   os_gen_top #(.lanes(lanes)) dut_i (.*);

   always #4 pclk = ~pclk;

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      return y ^ (y << 5);
   endfunction

   function automatic logic [31:0] draw();
      rng_state = xorshift32(rng_state);
      return rng_state;
   endfunction

   task automatic compare_field(input string name, input logic [127:0] actual,
                                input logic [127:0] expected);
      checks++;
      assert (actual === expected) else begin
         $display("[ERROR] %s expected 0x%0h got 0x%0h (request %0d, slot %0d)",
                  name, expected, actual, req_num, slot);
         errors++;
      end
   endtask

   task automatic check_quiet();
      compare_field("tx_data", 128'(tx_data), 128'(0));
      compare_field("tx_datak", 128'(tx_datak), 128'(0));
      compare_field("tx_valid", 128'(tx_valid), 128'(0));
      compare_field("finish", 128'(finish), 128'(0));
      compare_field("busy", 128'(busy), 128'(0));
   endtask

   // reference model of one ordered set on all lanes
   task automatic build_expected(input logic [2:0] t, input logic [1:0] mode,
                                 input logic [7:0] link, input logic [2:0] r, input logic lb);
      logic [7:0] sym_b;
      logic       sym_k;
      logic [7:0] rate_id;
      rate_id = (r >= 3'd1 && r <= 3'd4) ? (8'h01 << r) : 8'h20;
      exp_len = (t <= 3'd1) ? `OS_TS_LEN : (t <= 3'd3) ? `OS_SHORT_LEN : 0;
      for (int s = 0; s < `OS_TS_LEN; s++) begin
         sym_b = (s == 0) ? `OS_COM : (t == 3'd1) ? `OS_TS2_ID : `OS_TS1_ID;
         sym_k = (s == 0);
         case (s)
            1: begin
               sym_b = (link == 8'h00) ? `OS_PAD : link;
               sym_k = (link == 8'h00);
            end
            3:       sym_b = 8'h00;
            4:       sym_b = rate_id;
            5:       sym_b = lb ? 8'h04 : 8'h00;
            default: ;
         endcase
         if (t >= 3'd2) begin   // SKP and EIOS are all K
            sym_b = (s == 0) ? `OS_COM : (t == 3'd2) ? `OS_SKP : `OS_EIE;
            sym_k = 1'b1;
         end
         for (int i = 0; i < lanes; i++) begin
            exp_data[s][i*8 +: 8] = sym_b;
            exp_k[s][i]           = sym_k;
            if (s == 2 && t <= 3'd1) begin   // lane number field
               exp_data[s][i*8 +: 8] = (mode == 2'd0) ? `OS_PAD :
                                       (mode == 2'd1) ? 8'(i) : 8'(lanes - 1 - i);
               exp_k[s][i]           = (mode == 2'd0);
            end
         end
      end
   endtask

   task automatic run_request(input logic [2:0] t, input logic [1:0] mode, input logic [7:0] link,
                              input logic [2:0] r, input logic lb, input int spurious_at);
      int          fin_slot;
      int          waited;
      logic        seen;
      logic        exp_on;
      logic [31:0] noise;
      build_expected(t, mode, link, r, lb);
      fin_slot    = (exp_len == 0) ? 1 : exp_len;
      os_type     = t;
      lane_mode   = mode;
      link_number = link;
      rate        = r;
      loopback    = lb;
      start       = 1'b1;
      seen        = 1'b0;
      slot        = 0;
      while (!seen && slot < max_wait) begin
         @(negedge pclk);
         exp_on = (slot >= 1) && (slot <= exp_len);
         compare_field("tx_data", 128'(tx_data), exp_on ? 128'(exp_data[slot-1]) : 128'(0));
         compare_field("tx_datak", 128'(tx_datak), exp_on ? 128'(exp_k[slot-1]) : 128'(0));
         compare_field("tx_valid", 128'(tx_valid), exp_on ? 128'({lanes{1'b1}}) : 128'(0));
         compare_field("finish", 128'(finish), 128'(slot == fin_slot));
         compare_field("busy", 128'(busy), 128'(1));
         seen        = finish;
         noise       = draw();   // inputs change freely while the set runs
         start       = (slot == spurious_at);
         os_type     = noise[2:0];
         lane_mode   = noise[4:3];
         link_number = noise[12:5];
         rate        = noise[15:13];
         loopback    = noise[16];
         slot++;
      end
      start = 1'b0;
      assert (seen) else begin
         $display("timeout: no finish pulse within %0d cycles of request %0d", max_wait, req_num);
         timeouts++;
      end
      waited = 0;
      do begin
         @(negedge pclk);
         waited++;
      end while (busy && waited < max_wait);
      assert (waited == 1) else begin
         $display("busy fell %0d cycles after finish instead of 1 on request %0d", waited, req_num);
         errors++;
      end
      check_quiet();
   endtask

   initial begin
      int          gap;
      logic [31:0] rnd;
      logic [2:0]  t;
      rng_state   = 32'hbe97_b347;
      checks      = 0;
      errors      = 0;
      timeouts    = 0;
      req_num     = 0;
      slot        = 0;
      reset_n     = 1'b0;
      start       = 1'b0;
      os_type     = 3'd0;
      lane_mode   = 2'd0;
      link_number = 8'h00;
      rate        = 3'd0;
      loopback    = 1'b0;
      repeat (2) @(negedge pclk);
      reset_n = 1'b1;
      check_quiet();   // outputs after reset
      for (req_num = 0; req_num < num_reqs && timeouts == 0; req_num++) begin
         rnd = draw();
         if (req_num < 8)
            t = req_num[2:0];   // every type value once
         else
            t = (rnd[3:0] < 4'd14) ? {1'b0, rnd[1:0]} : {1'b1, rnd[5:4]};
         run_request(t, rnd[17:16], (rnd[7:6] == 2'b00) ? 8'h00 : rnd[15:8], rnd[20:18],
                     rnd[21], (t <= 3'd1 && rnd[22]) ? 1 + int'(rnd[25:23]) : -1);
         gap = int'(draw() % 6);
         repeat (gap) begin
            @(negedge pclk);
            check_quiet();
         end
      end
      $display("checks: %0d, errors: %0d, timeouts: %0d", checks, errors, timeouts);
      if (errors == 0 && timeouts == 0)
         $display("All tests passed!");
      else
         $display("Test failures found");
      $finish;
   end

endmodule

/* os_gen.f */
+incdir+verilog
verilog/os_gen_pkg.sv
verilog/os_request_capture.sv
verilog/os_symbol_sequencer.sv
verilog/pipe_lane_driver.sv
verilog/os_gen_top.sv
bench/os_gen_assertions.sv
bench/os_gen_tb.sv

/* run_sim.sh */
#!/bin/sh
# builds the testbench with Verilator, runs it and looks for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/100ps \
   --top-module os_gen_tb -f os_gen.f -o os_gen_sim || exit 1
out=$(./obj_dir/os_gen_sim) ; printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qx "All tests passed!" && exit 0 || exit 1
